// File: test/Core_testdata.txt
// Columns in hex: instruction word, expected rd, expected value, expected illegal bit
// Results are expected in this order, one per instruction
000000B3 01 00000000 0
01F28133 02 00000000 0
06400093 01 00000064 0
FF900113 02 FFFFFFF9 0
123451B7 03 12345000 0
00208233 04 0000005D 0
402082B3 05 0000006B 0
7FF18313 06 123457FF 0
002373B3 07 123457F9 0
0030E433 08 12345064 0
002344B3 09 EDCBA806 0
00131533 0A 23457FF0 0
001155B3 0B 0FFFFFFF 0
40115633 0C FFFFFFFF 0
01809693 0D 64000000 0
0084D713 0E 00EDCBA8 0
4084D793 0F FFEDCBA8 0
00112833 10 00000001 0
001138B3 11 00000000 0
FFF12913 12 00000001 0
FFF0B993 13 00000001 0
00100A13 14 00000001 0
014A0A33 14 00000002 0
014A0AB3 15 00000004 0
401A8B33 16 FFFFFFA0 0
03708013 00 0000009B 0
00000BB3 17 00000000 0
00000203 04 00000000 1
00020C13 18 0000005D 0

// File: sim.f
hdl/rvIsaPkg.sv
hdl/corePkg.sv
hdl/uopIf.sv
hdl/InstrDecoder.sv
hdl/RegFile.sv
hdl/IntALU.sv
hdl/ResultStage.sv
hdl/Core.sv
test/ClockGen.sv
test/Core_assert.sv
test/Core_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator and run from the project root; exit status is 0 only on a passing run
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal --top-module Core_tb -f sim.f \
    && ./obj_dir/VCore_tb | tee /dev/stderr | grep -q "All tests passed" \
    && echo "Simulation finished without errors" \
    || { echo "Simulation reported a failure"; exit 1; }

// File: test/Core_tb.sv
`default_nettype none
`timescale 1ns/100ps

module Core_tb;

    localparam int maxLines   = 64;
    localparam int idleCycles = 5;

    logic        clk;
    logic        rst;
    logic        instrValid;
    logic        instrReady;
    logic [31:0] instr;
    logic        resValid;
    logic        resReady;
    logic [4:0]  resRd;
    logic [31:0] resValue;
    logic        resIllegal;

    logic [31:0] testData [maxLines*4];         // Four words per line of the data file
    int          numInstr   = 0;
    int          sent       = 0;
    int          retired    = 0;
    int          cycleCount = 0;

    ClockGen clockGen (.clk(clk), .rst(rst));

    Core #(
        .numRegs    (32)
    ) u_Core (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .instr      (instr),
        .resValid   (resValid),
        .resReady   (resReady),
        .resRd      (resRd),
        .resValue   (resValue),
        .resIllegal (resIllegal)
    );

    bind Core Core_assert coreChecks (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .instr      (instr),
        .resValid   (resValid),
        .resReady   (resReady),
        .resRd      (resRd),
        .resValue   (resValue),
        .resIllegal (resIllegal),
        .retire     (retire),
        .retireRd   (retireRd)
    );

    task automatic stopOnError(input string what);
        $display("%s", what);
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    // Entries left untouched by the data file keep this pattern
    function automatic logic [31:0] fillWord(input int addr);
        return 32'hC0DE_0000 ^ addr;
    endfunction

    function automatic int countLines();
        int n;
        n = 0;
        while (n < maxLines && testData[4*n] != fillWord(4*n))
            n++;
        return n;
    endfunction

    task automatic checkResult(input int idx);
        logic [4:0]  expRd;
        logic [31:0] expValue;
        logic        expIllegal;
        expRd      = testData[4*idx+1][4:0];
        expValue   = testData[4*idx+2];
        expIllegal = testData[4*idx+3][0];
        assert (resRd == expRd && resValue == expValue && resIllegal == expIllegal)
            else stopOnError($sformatf(
                "Mismatch at time %0t: result %0d expected rd %0d value %08h illegal %0b, %s",
                $time, idx, expRd, expValue, expIllegal,
                $sformatf("got rd %0d value %08h illegal %0b", resRd, resValue, resIllegal)));
    endtask

    // Nothing may come out while no instruction has been sent
    task automatic checkIdle();
        repeat (idleCycles) begin
            @(negedge clk);
            resReady = 1'b1;
            #1;
            assert (!resValid)
                else stopOnError("A result appeared before any instruction was sent");
            assert (instrReady)
                else stopOnError("The decoder was not ready after reset");
        end
    endtask

    // Inputs change on the falling edge and the handshakes are sampled 1 ns later
    task automatic stepCycle();
        @(negedge clk);
        instrValid = (sent < numInstr);
        instr      = instrValid ? testData[4*sent] : 32'd0;
        resReady   = ($urandom_range(99) < 70);  // About 70% of cycles take a result
        #1;
        if (resValid && resReady) begin
            checkResult(retired);
            retired++;
        end
        if (instrValid && instrReady)
            sent++;
    endtask

    task automatic checkDrained();
        repeat (idleCycles) begin
            @(negedge clk);
            instrValid = 1'b0;
            resReady   = 1'b1;
            #1;
            assert (!resValid)
                else stopOnError("An extra result appeared after the last instruction retired");
        end
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (numInstr > 0 && cycleCount >= 20 * numInstr + 50)
            stopOnError("Timeout: not all results arrived within the cycle limit");
    end

    initial begin
        instrValid = 1'b0;
        instr      = 32'd0;
        resReady   = 1'b0;
        void'($urandom(32'h6960_9786));
        for (int i = 0; i < maxLines * 4; i++)
            testData[i] = fillWord(i);
        $readmemh("test/Core_testdata.txt", testData);
        numInstr = countLines();
        if (numInstr == 0)
            stopOnError("No instructions were found in test/Core_testdata.txt");
        @(negedge clk);
        while (rst)
            @(negedge clk);
        checkIdle();
        while (retired < numInstr)
            stepCycle();
        checkDrained();
        if (sent == numInstr && retired == numInstr) begin
            $display("All tests passed");
            $finish;
        end else begin
            stopOnError("Sent and retired instruction counts differ at the end of the run");
        end
    end

endmodule

`default_nettype wire

// File: test/Core_assert.sv
`default_nettype none
`timescale 1ns/100ps

module Core_assert (
    input logic        clk,
    input logic        rst,
    input logic        instrValid,
    input logic        instrReady,
    input logic [31:0] instr,
    input logic        resValid,
    input logic        resReady,
    input logic [4:0]  resRd,
    input logic [31:0] resValue,
    input logic        resIllegal,
    input logic        retire,
    input logic [4:0]  retireRd
);

    resultHeld: assert property (@(posedge clk) disable iff (rst)
        resValid && !resReady |=> resValid && $stable({resRd, resValue, resIllegal}))
        else $error("Result port changed while the result was stalled");

    instrHeld: assert property (@(posedge clk) disable iff (rst)
        instrValid && !instrReady |=> instrValid && $stable(instr))
        else $error("Instruction input changed while it was stalled");

    resetQuiet: assert property (@(posedge clk) rst |=> !resValid)
        else $error("Result valid was high right after a reset cycle");

    // A retire strobe belongs to the legal op that shows up next at the result port
    retireMatchesResult: assert property (@(posedge clk) disable iff (rst)
        retire |=> resValid && !resIllegal && resRd != 5'd0 && resRd == $past(retireRd))
        else $error("Retire strobe did not match a legal result for a nonzero register");

endmodule

`default_nettype wire

// File: test/ClockGen.sv
`default_nettype none
`timescale 1ns/100ps

module ClockGen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                  // 4 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;                            // Released after the third rising edge
    end

endmodule

`default_nettype wire

// File: hdl/Core.sv
`default_nettype none
`timescale 1ns/100ps

module Core #(
    parameter int numRegs = 32                  // 16 gives an RV32E-sized register file
)(
    input  logic        clk,
    input  logic        rst,
    input  logic        instrValid,
    output logic        instrReady,
    input  logic [31:0] instr,
    output logic        resValid,
    input  logic        resReady,
    output logic [4:0]  resRd,
    output logic [31:0] resValue,
    output logic        resIllegal
);

    logic [4:0]  rdAddrA;
    logic [4:0]  rdAddrB;
    logic [31:0] rdDataA;
    logic [31:0] rdDataB;
    logic        wrEn;
    logic [4:0]  wrAddr;
    logic [31:0] wrData;
    logic        retire;
    logic [4:0]  retireRd;

    uopIf decodeToExec ();
    uopIf execToResult ();

    InstrDecoder #(
        .numRegs    (numRegs)
    ) decoder (
        .clk        (clk),
        .rst        (rst),
        .instrValid (instrValid),
        .instrReady (instrReady),
        .instr      (instr),
        .rdAddrA    (rdAddrA),
        .rdAddrB    (rdAddrB),
        .rdDataA    (rdDataA),
        .rdDataB    (rdDataB),
        .retire     (retire),
        .retireRd   (retireRd),
        .out        (decodeToExec.producer)
    );

    RegFile #(
        .numRegs (numRegs)
    ) regFile (
        .clk     (clk),
        .rst     (rst),
        .rdAddrA (rdAddrA),
        .rdAddrB (rdAddrB),
        .rdDataA (rdDataA),
        .rdDataB (rdDataB),
        .wrEn    (wrEn),
        .wrAddr  (wrAddr),
        .wrData  (wrData)
    );

    IntALU alu (
        .clk (clk),
        .rst (rst),
        .in  (decodeToExec.consumer),
        .out (execToResult.producer)
    );

    ResultStage resultStage (
        .clk        (clk),
        .rst        (rst),
        .in         (execToResult.consumer),
        .wrEn       (wrEn),
        .wrAddr     (wrAddr),
        .wrData     (wrData),
        .retire     (retire),
        .retireRd   (retireRd),
        .resValid   (resValid),
        .resReady   (resReady),
        .resRd      (resRd),
        .resValue   (resValue),
        .resIllegal (resIllegal)
    );

endmodule

`default_nettype wire

// File: hdl/ResultStage.sv
`default_nettype none
`timescale 1ns/100ps

module ResultStage
    import corePkg::*;
(
    input  logic        clk,
    input  logic        rst,
    uopIf.consumer      in,
    output logic        wrEn,
    output logic [4:0]  wrAddr,
    output logic [31:0] wrData,
    output logic        retire,
    output logic [4:0]  retireRd,
    output logic        resValid,
    input  logic        resReady,
    output logic [4:0]  resRd,
    output logic [31:0] resValue,
    output logic        resIllegal
);

    logic   accept;
    logic   validReg;
    RES_UOp held;

    assign in.ready = !validReg || resReady;
    assign accept   = in.valid && in.ready;

    // Write back as the op enters, so the pending bit clears on the same edge
    assign wrEn     = accept && !in.res.illegal && in.res.rd != 5'd0;
    assign wrAddr   = in.res.rd;
    assign wrData   = in.res.result;
    assign retire   = wrEn;                     // Only ops that set a pending bit clear one
    assign retireRd = in.res.rd;

    always_ff @(posedge clk) begin
        if (rst)
            validReg <= 1'b0;
        else if (accept)
            validReg <= 1'b1;
        else if (resReady)
            validReg <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept)
            held <= in.res;
    end

    assign resValid   = validReg;
    assign resRd      = held.rd;
    assign resValue   = held.result;
    assign resIllegal = held.illegal;

endmodule

`default_nettype wire

// File: hdl/IntALU.sv
`default_nettype none
`timescale 1ns/100ps

module IntALU
    import corePkg::*;
(
    input  logic   clk,
    input  logic   rst,
    uopIf.consumer in,
    uopIf.producer out
);

    logic [31:0] a;
    logic [31:0] b;
    logic [4:0]  shamt;
    logic [31:0] value;
    logic        accept;
    logic        validReg;
    RES_UOp      resReg;

    assign a     = in.uop.srcA;
    assign b     = in.uop.srcB;
    assign shamt = b[4:0];

    always_comb begin
        case (in.uop.op)
            ADD:     value = a + b;
            SUB:     value = a - b;
            SLL:     value = a << shamt;
            SLT:     value = {31'd0, $signed(a) < $signed(b)};
            SLTU:    value = {31'd0, a < b};
            XOR:     value = a ^ b;
            SRL:     value = a >> shamt;
            SRA:     value = $unsigned($signed(a) >>> shamt);
            OR:      value = a | b;
            AND:     value = a & b;
            PASSB:   value = b;
            default: value = '0;
        endcase
        if (in.uop.illegal)
            value = '0;                         // Illegal ops retire with value 0
    end

    assign in.ready = !validReg || out.ready;
    assign accept   = in.valid && in.ready;

    always_ff @(posedge clk) begin
        if (rst)
            validReg <= 1'b0;
        else if (accept)
            validReg <= 1'b1;
        else if (out.ready)
            validReg <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resReg.result  <= value;
            resReg.rd      <= in.uop.rd;
            resReg.illegal <= in.uop.illegal;
        end
    end

    assign out.valid = validReg;
    assign out.res   = resReg;
    assign out.uop   = '0;                      // Operands are consumed here

endmodule

`default_nettype wire

// File: hdl/RegFile.sv
`default_nettype none
`timescale 1ns/100ps

module RegFile #(
    parameter int numRegs = 32
)(
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  rdAddrA,
    input  logic [4:0]  rdAddrB,
    output logic [31:0] rdDataA,
    output logic [31:0] rdDataB,
    input  logic        wrEn,
    input  logic [4:0]  wrAddr,
    input  logic [31:0] wrData
);

    localparam int idxW = $clog2(numRegs);

    logic [31:0] regs [numRegs];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < numRegs; i++)
                regs[i] <= '0;
        end else if (wrEn && wrAddr != 5'd0) begin
            regs[wrAddr[idxW-1:0]] <= wrData;
        end
    end

    // x0 is hardwired to zero
    assign rdDataA = (rdAddrA == 5'd0) ? 32'd0 : regs[rdAddrA[idxW-1:0]];
    assign rdDataB = (rdAddrB == 5'd0) ? 32'd0 : regs[rdAddrB[idxW-1:0]];

endmodule

`default_nettype wire

// File: hdl/InstrDecoder.sv
`default_nettype none
`timescale 1ns/100ps

module InstrDecoder
    import rvIsaPkg::*;
    import corePkg::*;
#(
    parameter int numRegs = 32
)(
    input  logic        clk,
    input  logic        rst,
    input  logic        instrValid,
    output logic        instrReady,
    input  Instr        instr,
    output logic [4:0]  rdAddrA,
    output logic [4:0]  rdAddrB,
    input  logic [31:0] rdDataA,
    input  logic [31:0] rdDataB,
    input  logic        retire,
    input  logic [4:0]  retireRd,
    uopIf.producer      out
);

    localparam int idxW = $clog2(numRegs);

    D_UOp               dec;
    D_UOp               uopReg;
    logic               validReg;
    logic               useA;
    logic               useB;
    logic               writesRd;
    logic               hazard;
    logic               accept;
    logic [numRegs-1:0] pending;
    logic [numRegs-1:0] setMask;
    logic [numRegs-1:0] clrMask;

    assign rdAddrA = instr.r.rs1;
    assign rdAddrB = instr.r.rs2;

    always_comb begin
        dec      = '0;
        dec.srcA = rdDataA;
        dec.srcB = rdDataB;
        dec.rd   = instr.r.rd;
        useA     = 1'b0;
        useB     = 1'b0;
        // OP-IMM has no SUB, but SRAI keeps the funct7 bit in the immediate
        case (instr.r.funct3)
            F3_ADD_SUB: dec.op = (instr.r.opcode == OPC_OP && instr.r.funct7[5]) ? SUB : ADD;
            F3_SLL:     dec.op = SLL;
            F3_SLT:     dec.op = SLT;
            F3_SLTU:    dec.op = SLTU;
            F3_XOR:     dec.op = XOR;
            F3_SRL_SRA: dec.op = instr.r.funct7[5] ? SRA : SRL;
            F3_OR:      dec.op = OR;
            default:    dec.op = AND;
        endcase
        case (instr.r.opcode)
            OPC_OP: begin
                useA = 1'b1;
                useB = 1'b1;
            end
            OPC_OP_IMM: begin
                useA     = 1'b1;
                dec.srcB = {{20{instr.i.imm12[11]}}, instr.i.imm12};
            end
            OPC_LUI: begin
                dec.op   = PASSB;
                dec.srcB = {instr.i.imm12, instr.i.rs1, instr.i.funct3, 12'b0};
            end
            default: dec.illegal = 1'b1;
        endcase
    end

    assign writesRd = !dec.illegal && dec.rd != 5'd0;

    // A pending destination also stalls, so an older retire cannot clear the bit of a younger op
    assign hazard = (useA && pending[instr.r.rs1[idxW-1:0]]) ||
                    (useB && pending[instr.r.rs2[idxW-1:0]]) ||
                    (writesRd && pending[dec.rd[idxW-1:0]]);

    assign instrReady = !hazard && (!validReg || out.ready);
    assign accept     = instrValid && instrReady;

    always_comb begin
        setMask = '0;
        clrMask = '0;
        if (accept && writesRd)
            setMask[dec.rd[idxW-1:0]] = 1'b1;
        if (retire)
            clrMask[retireRd[idxW-1:0]] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending  <= '0;
            validReg <= 1'b0;
        end else begin
            pending <= (pending & ~clrMask) | setMask;  // Set wins when both hit one register
            if (accept)
                validReg <= 1'b1;
            else if (out.ready)
                validReg <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept)
            uopReg <= dec;
    end

    assign out.valid = validReg;
    assign out.uop   = uopReg;
    assign out.res   = '0;                      // No computed result at this stage

endmodule

`default_nettype wire

// File: hdl/uopIf.sv
`default_nettype none
`timescale 1ns/100ps

interface uopIf
    import corePkg::*;
();

    logic   valid;
    logic   ready;
    D_UOp   uop;                                // Decoded op, used between decode and execute
    RES_UOp res;                                // Computed op, used between execute and result

    modport producer (
        output valid,
        output uop,
        output res,
        input  ready
    );

    modport consumer (
        input  valid,
        input  uop,
        input  res,
        output ready
    );

endinterface

`default_nettype wire

// File: hdl/corePkg.sv
`default_nettype none

package corePkg;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASSB                                   // Operand b straight through, used by LUI
    } AluOp;

    typedef struct packed {
        logic [31:0] srcA;
        logic [31:0] srcB;                      // Register value or immediate
        AluOp        op;
        logic [4:0]  rd;
        logic        illegal;
    } D_UOp;

    typedef struct packed {
        logic [31:0] result;
        logic [4:0]  rd;
        logic        illegal;
    } RES_UOp;

endpackage

`default_nettype wire

// File: hdl/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    typedef struct packed {
        logic [6:0] funct7;                     // Bit 5 selects SUB and SRA
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } RTypeInstr;

    typedef struct packed {
        logic [11:0] imm12;                     // Same bits as funct7 and rs2
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } ITypeInstr;

    typedef union packed {
        RTypeInstr r;
        ITypeInstr i;
    } Instr;

endpackage

`default_nettype wire
